// ==== verilog/cache_cfg_pkg.sv ====
// Address map, cache geometry constants, request route and controller state types
package cache_cfg_pkg;

	// ------------------------------------------------------------
	// Data path widths
	// ------------------------------------------------------------

	localparam int ADDR_W = 32;
	localparam int WORD_W = 32;
	localparam int LINE_W = 128;

	// Line geometry
	localparam int WORDS_PER_LINE = 4;
	localparam int OFFSET_W = 2;
	// Byte bits below the word select
	localparam int BYTE_OFFSET_W = 2;
	localparam int LINE_ADDR_W = ADDR_W - OFFSET_W - BYTE_OFFSET_W;

	// ------------------------------------------------------------
	// Address map
	// ------------------------------------------------------------

	// Always sent to main memory
	localparam logic [ADDR_W-1:0] DIRECT_ADDR = 32'h0000_0000;
	// Boundary control register
	localparam logic [ADDR_W-1:0] CTRL_REG_ADDR = 32'h0000_0004;

	// Path taken by a captured request
	typedef enum logic [2:0] {
		ROUTE_DIRECT,
		ROUTE_CTRL_WRITE,
		ROUTE_EMPTY,
		ROUTE_CACHED
	} route_t;

	// Router FSM states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ISSUE,
		ST_LOCAL,
		ST_CACHE_WAIT,
		ST_DIR_WAIT,
		ST_RESP
	} ctrl_state_t;

endpackage

// ==== verilog/mem_msg_pkg.sv ====
// Request and response message structs for the processor word port and memory line port
package mem_msg_pkg;
	import cache_cfg_pkg::*;

	typedef enum logic {
		MEM_READ  = 1'b0,
		MEM_WRITE = 1'b1
	} mem_op_t;

	// ------------------------------------------------------------
	// Word port, processor side
	// ------------------------------------------------------------

	typedef struct packed {
		mem_op_t           op;
		logic [ADDR_W-1:0] addr;
		logic [WORD_W-1:0] data;
	} word_req_t;

	typedef struct packed {
		mem_op_t           op;
		logic [WORD_W-1:0] data;
	} word_resp_t;

	// ------------------------------------------------------------
	// Line port, main memory side
	// ------------------------------------------------------------

	// Mask has one bit per word lane; reads set every lane
	typedef struct packed {
		mem_op_t                   op;
		logic [LINE_ADDR_W-1:0]    addr;
		logic [WORDS_PER_LINE-1:0] mask;
		logic [LINE_W-1:0]         data;
	} line_req_t;

	typedef struct packed {
		mem_op_t           op;
		logic [LINE_W-1:0] data;
	} line_resp_t;

endpackage

// ==== verilog/request_router.sv ====
// Request capture, address classification, boundary register and router FSM
module request_router
	import cache_cfg_pkg::*;
	import mem_msg_pkg::*;
#(
	parameter logic [ADDR_W-1:0] BOUNDARY_RESET = 32'hc000
) (
	input  logic       clk,
	input  logic       reset,

	// Processor side
	input  word_req_t  proc_req,
	input  logic       proc_req_domain,
	input  logic       proc_req_val,
	output logic       proc_req_rdy,
	output word_resp_t proc_resp,
	output logic       proc_resp_val,
	input  logic       proc_resp_rdy,

	// Captured request, seen by cache and arbiter
	output word_req_t  cur_req,

	// Cache path
	output logic       cache_req_val,
	input  logic       cache_req_rdy,
	input  word_resp_t cache_resp,
	input  logic       cache_resp_val,

	// Direct memory path
	output logic       dir_req_val,
	input  word_resp_t dir_resp,
	input  logic       dir_resp_val
);

	ctrl_state_t       state;
	ctrl_state_t       state_next;
	logic              cur_domain;
	logic [ADDR_W-1:0] boundary;
	logic              cacheable;
	route_t            route;
	word_resp_t        resp_q;

	// ------------------------------------------------------------
	// Classification
	// ------------------------------------------------------------

	// Cacheable only below the boundary
	assign cacheable = boundary > cur_req.addr;

	always_comb begin
		if (cur_req.addr == DIRECT_ADDR) begin
			route = ROUTE_DIRECT;
		end else if (cur_req.addr == CTRL_REG_ADDR) begin
			// Only a privileged write touches the boundary
			if (cur_domain && cur_req.op == MEM_WRITE) begin
				route = ROUTE_CTRL_WRITE;
			end else begin
				route = ROUTE_EMPTY;
			end
		end else if (cacheable) begin
			route = ROUTE_CACHED;
		end else begin
			route = ROUTE_DIRECT;
		end
	end

	// ------------------------------------------------------------
	// FSM
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: begin
				if (proc_req_val) begin
					state_next = ST_ISSUE;
				end
			end
			ST_ISSUE: begin
				case (route)
					ROUTE_CACHED: begin
						if (cache_req_rdy) begin
							state_next = ST_CACHE_WAIT;
						end
					end
					ROUTE_DIRECT: state_next = ST_DIR_WAIT;
					default:      state_next = ST_LOCAL;
				endcase
			end
			ST_LOCAL: state_next = ST_RESP;
			ST_CACHE_WAIT: begin
				if (cache_resp_val) begin
					state_next = ST_RESP;
				end
			end
			ST_DIR_WAIT: begin
				if (dir_resp_val) begin
					state_next = ST_RESP;
				end
			end
			ST_RESP: begin
				if (proc_resp_rdy) begin
					state_next = ST_IDLE;
				end
			end
			default: state_next = ST_IDLE;
		endcase
	end

	// Boundary register
	always_ff @(posedge clk) begin
		if (reset) begin
			boundary <= BOUNDARY_RESET;
		end else if (state == ST_ISSUE && route == ROUTE_CTRL_WRITE) begin
			boundary <= cur_req.data;
		end
	end

	// Request and response payload
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && proc_req_val) begin
			cur_req    <= proc_req;
			cur_domain <= proc_req_domain;
		end
		case (state)
			ST_LOCAL: begin
				// Local answer carries no data
				resp_q.op   <= cur_req.op;
				resp_q.data <= '0;
			end
			ST_CACHE_WAIT: begin
				if (cache_resp_val) begin
					resp_q <= cache_resp;
				end
			end
			ST_DIR_WAIT: begin
				if (dir_resp_val) begin
					resp_q <= dir_resp;
				end
			end
			default: ;
		endcase
	end

	assign proc_req_rdy  = state == ST_IDLE;
	assign proc_resp_val = state == ST_RESP;
	assign proc_resp     = resp_q;
	assign cache_req_val = (state == ST_ISSUE) && (route == ROUTE_CACHED);
	assign dir_req_val   = (state == ST_ISSUE) && (route == ROUTE_DIRECT);

endmodule

// ==== verilog/line_cache.sv ====
// Direct-mapped cache arrays with hit check, line refill and write-through update
module line_cache
	import cache_cfg_pkg::*;
	import mem_msg_pkg::*;
#(
	parameter int NUM_LINES = 16
) (
	input  logic       clk,
	input  logic       reset,

	// Request from the router
	input  word_req_t  cache_req,
	input  logic       cache_req_val,
	output logic       cache_req_rdy,
	output word_resp_t cache_resp,
	output logic       cache_resp_val,

	// Refill and write-through path
	output word_req_t  fill_req,
	output logic       fill_req_val,
	input  logic       fill_req_rdy,
	input  line_resp_t fill_resp,
	input  logic       fill_resp_val
);

	localparam int IDX_W = $clog2(NUM_LINES);
	localparam int TAG_W = ADDR_W - IDX_W - OFFSET_W - BYTE_OFFSET_W;

	typedef enum logic [2:0] {
		C_IDLE,
		C_LOOKUP,
		C_FILL_REQ,
		C_FILL_WAIT,
		C_RESP
	} cache_state_t;

	cache_state_t         state;
	word_req_t            req_q;
	word_resp_t           resp_q;
	logic [NUM_LINES-1:0] valid;
	logic [TAG_W-1:0]     tag_arr [NUM_LINES];
	logic [LINE_W-1:0]    data_arr [NUM_LINES];

	logic [OFFSET_W-1:0]  offset;
	logic [IDX_W-1:0]     idx;
	logic [TAG_W-1:0]     tag;
	logic                 hit;
	logic                 read_hit;
	logic [WORD_W-1:0]    hit_word;
	logic [WORD_W-1:0]    fill_word;

	// ------------------------------------------------------------
	// Address split and lookup
	// ------------------------------------------------------------

	assign offset = req_q.addr[BYTE_OFFSET_W +: OFFSET_W];
	assign idx    = req_q.addr[BYTE_OFFSET_W + OFFSET_W +: IDX_W];
	assign tag    = req_q.addr[ADDR_W-1 -: TAG_W];

	assign hit       = valid[idx] && (tag_arr[idx] == tag);
	assign read_hit  = hit && (req_q.op == MEM_READ);
	assign hit_word  = data_arr[idx][offset*WORD_W +: WORD_W];
	assign fill_word = fill_resp.data[offset*WORD_W +: WORD_W];

	// ------------------------------------------------------------
	// FSM
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= C_IDLE;
		end else begin
			case (state)
				C_IDLE: begin
					if (cache_req_val) begin
						state <= C_LOOKUP;
					end
				end
				// Writes always go out, hit or not
				C_LOOKUP: state <= read_hit ? C_RESP : C_FILL_REQ;
				C_FILL_REQ: begin
					if (fill_req_rdy) begin
						state <= C_FILL_WAIT;
					end
				end
				C_FILL_WAIT: begin
					if (fill_resp_val) begin
						state <= C_RESP;
					end
				end
				C_RESP:  state <= C_IDLE;
				default: state <= C_IDLE;
			endcase
		end
	end

	// Valid bits, set on a read refill only
	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= '0;
		end else if (state == C_FILL_WAIT && fill_resp_val && req_q.op == MEM_READ) begin
			valid[idx] <= 1'b1;
		end
	end

	// Arrays, captured request and response word
	always_ff @(posedge clk) begin
		if (state == C_IDLE && cache_req_val) begin
			req_q <= cache_req;
		end
		if (state == C_LOOKUP && read_hit) begin
			resp_q.op   <= MEM_READ;
			resp_q.data <= hit_word;
		end
		if (state == C_FILL_WAIT && fill_resp_val) begin
			resp_q.op <= req_q.op;
			if (req_q.op == MEM_READ) begin
				data_arr[idx] <= fill_resp.data;
				tag_arr[idx]  <= tag;
				resp_q.data   <= fill_word;
			end else begin
				// No allocate on a write miss
				if (hit) begin
					data_arr[idx][offset*WORD_W +: WORD_W] <= req_q.data;
				end
				resp_q.data <= '0;
			end
		end
	end

	assign cache_req_rdy  = state == C_IDLE;
	assign cache_resp_val = state == C_RESP;
	assign cache_resp     = resp_q;
	assign fill_req       = req_q;
	assign fill_req_val   = state == C_FILL_REQ;

endmodule

// ==== verilog/mem_port_arbiter.sv ====
// Memory port owner tracking, word to line packing and direct response word select
module mem_port_arbiter
	import cache_cfg_pkg::*;
	import mem_msg_pkg::*;
(
	input  logic       clk,
	input  logic       reset,

	input  word_req_t  dir_req,
	input  logic       dir_req_val,
	output word_resp_t dir_resp,
	output logic       dir_resp_val,

	input  word_req_t  fill_req,
	input  logic       fill_req_val,
	output logic       fill_req_rdy,
	output line_resp_t fill_resp,
	output logic       fill_resp_val,

	output line_req_t  mem_req,
	output logic       mem_req_val,
	input  logic       mem_req_rdy,
	input  line_resp_t mem_resp,
	input  logic       mem_resp_val,
	output logic       mem_resp_rdy
);

	typedef enum logic [1:0] {A_IDLE, A_REQ, A_WAIT, A_RESP} arb_state_t;
	typedef enum logic {OWN_DIR, OWN_FILL} owner_t;

	arb_state_t          state;
	owner_t              owner;
	line_req_t           req_q;
	line_resp_t          resp_q;
	logic [OFFSET_W-1:0] offset_q;
	word_req_t           sel_req;
	logic                take;

	// Word write lands in its own lane with a one-hot mask
	function automatic line_req_t pack_req(input word_req_t w);
		line_req_t           l;
		logic [OFFSET_W-1:0] off;
		off    = w.addr[BYTE_OFFSET_W +: OFFSET_W];
		l.op   = w.op;
		l.addr = w.addr[ADDR_W-1 -: LINE_ADDR_W];
		l.data = '0;
		l.data[off*WORD_W +: WORD_W] = w.data;
		if (w.op == MEM_WRITE) begin
			l.mask      = '0;
			l.mask[off] = 1'b1;
		end else begin
			l.mask = '1;
		end
		return l;
	endfunction

	assign take         = (state == A_IDLE) && (dir_req_val || fill_req_val);
	assign sel_req      = dir_req_val ? dir_req : fill_req;
	assign fill_req_rdy = (state == A_IDLE) && !dir_req_val;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= A_IDLE;
			owner <= OWN_DIR;
		end else begin
			case (state)
				A_IDLE: begin
					if (take) begin
						state <= A_REQ;
						owner <= dir_req_val ? OWN_DIR : OWN_FILL;
					end
				end
				A_REQ:   state <= mem_req_rdy ? A_WAIT : A_REQ;
				A_WAIT:  state <= mem_resp_val ? A_RESP : A_WAIT;
				default: state <= A_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			req_q    <= pack_req(sel_req);
			offset_q <= sel_req.addr[BYTE_OFFSET_W +: OFFSET_W];
		end
		if (state == A_WAIT && mem_resp_val) begin
			resp_q <= mem_resp;
		end
	end

	// Write acknowledgements return no data to the router
	always_comb begin
		dir_resp.op = resp_q.op;
		if (resp_q.op == MEM_WRITE) begin
			dir_resp.data = '0;
		end else begin
			dir_resp.data = resp_q.data[offset_q*WORD_W +: WORD_W];
		end
	end

	assign mem_req       = req_q;
	assign mem_req_val   = state == A_REQ;
	assign mem_resp_rdy  = state == A_WAIT;
	assign fill_resp     = resp_q;
	assign dir_resp_val  = (state == A_RESP) && (owner == OWN_DIR);
	assign fill_resp_val = (state == A_RESP) && (owner == OWN_FILL);

endmodule

// ==== verilog/l2_cache_top.sv ====
// Cache controller top level with router, line cache and memory port arbiter
module l2_cache_top
	import cache_cfg_pkg::*;
	import mem_msg_pkg::*;
#(
	parameter logic [ADDR_W-1:0] BOUNDARY_RESET = 32'hc000,
	parameter int                NUM_LINES      = 16
) (
	input  logic       clk,
	input  logic       reset,

	input  word_req_t  proc_req,
	input  logic       proc_req_domain,
	input  logic       proc_req_val,
	output logic       proc_req_rdy,
	output word_resp_t proc_resp,
	output logic       proc_resp_val,
	input  logic       proc_resp_rdy,

	output line_req_t  mem_req,
	output logic       mem_req_val,
	input  logic       mem_req_rdy,
	input  line_resp_t mem_resp,
	input  logic       mem_resp_val,
	output logic       mem_resp_rdy
);

	word_req_t  cur_req;
	logic       cache_req_val;
	logic       cache_req_rdy;
	word_resp_t cache_resp;
	logic       cache_resp_val;
	logic       dir_req_val;
	word_resp_t dir_resp;
	logic       dir_resp_val;
	word_req_t  fill_req;
	logic       fill_req_val;
	logic       fill_req_rdy;
	line_resp_t fill_resp;
	logic       fill_resp_val;

	request_router #(
		.BOUNDARY_RESET (BOUNDARY_RESET)
	) u_router (
		.clk            (clk),
		.reset          (reset),
		.proc_req       (proc_req),
		.proc_req_domain(proc_req_domain),
		.proc_req_val   (proc_req_val),
		.proc_req_rdy   (proc_req_rdy),
		.proc_resp      (proc_resp),
		.proc_resp_val  (proc_resp_val),
		.proc_resp_rdy  (proc_resp_rdy),
		.cur_req        (cur_req),
		.cache_req_val  (cache_req_val),
		.cache_req_rdy  (cache_req_rdy),
		.cache_resp     (cache_resp),
		.cache_resp_val (cache_resp_val),
		.dir_req_val    (dir_req_val),
		.dir_resp       (dir_resp),
		.dir_resp_val   (dir_resp_val)
	);

	line_cache #(
		.NUM_LINES      (NUM_LINES)
	) u_cache (
		.clk            (clk),
		.reset          (reset),
		.cache_req      (cur_req),
		.cache_req_val  (cache_req_val),
		.cache_req_rdy  (cache_req_rdy),
		.cache_resp     (cache_resp),
		.cache_resp_val (cache_resp_val),
		.fill_req       (fill_req),
		.fill_req_val   (fill_req_val),
		.fill_req_rdy   (fill_req_rdy),
		.fill_resp      (fill_resp),
		.fill_resp_val  (fill_resp_val)
	);

	// Router and cache never request at the same time
	mem_port_arbiter u_arbiter (
		.clk            (clk),
		.reset          (reset),
		.dir_req        (cur_req),
		.dir_req_val    (dir_req_val),
		.dir_resp       (dir_resp),
		.dir_resp_val   (dir_resp_val),
		.fill_req       (fill_req),
		.fill_req_val   (fill_req_val),
		.fill_req_rdy   (fill_req_rdy),
		.fill_resp      (fill_resp),
		.fill_resp_val  (fill_resp_val),
		.mem_req        (mem_req),
		.mem_req_val    (mem_req_val),
		.mem_req_rdy    (mem_req_rdy),
		.mem_resp       (mem_resp),
		.mem_resp_val   (mem_resp_val),
		.mem_resp_rdy   (mem_resp_rdy)
	);

endmodule

// ==== tb/l2_cache_assertions.sv ====
// Handshake and reset assertions bound to the cache controller top level
module l2_cache_assertions
	import mem_msg_pkg::*;
(
	input logic       clk,
	input logic       reset,
	input logic       proc_req_rdy,
	input word_resp_t proc_resp,
	input logic       proc_resp_val,
	input logic       proc_resp_rdy,
	input line_req_t  mem_req,
	input logic       mem_req_val,
	input logic       mem_req_rdy,
	input logic       mem_resp_rdy
);

	// Number of failed assertions
	int assert_errors = 0;

	// ------------------------------------------------------------
	// Handshake rules
	// ------------------------------------------------------------

	// Response payload frozen under back-pressure
	property resp_held_p;
		@(posedge clk) disable iff (reset)
		proc_resp_val && !proc_resp_rdy |=> proc_resp_val && $stable(proc_resp);
	endproperty

	property mem_req_held_p;
		@(posedge clk) disable iff (reset)
		mem_req_val && !mem_req_rdy |=> mem_req_val && $stable(mem_req);
	endproperty

	// Router busy while a response is pending
	property no_accept_during_resp_p;
		@(posedge clk) disable iff (reset)
		proc_resp_val |-> !proc_req_rdy;
	endproperty

	// All valids and the memory ready drop out of reset
	property reset_quiet_p;
		@(posedge clk)
		reset |=> !proc_resp_val && !mem_req_val && !mem_resp_rdy;
	endproperty

	resp_held_a: assert property (resp_held_p) else begin
		assert_errors++;
		$error("processor response changed or dropped before it was accepted");
	end

	mem_req_held_a: assert property (mem_req_held_p) else begin
		assert_errors++;
		$error("memory request changed or dropped before it was accepted");
	end

	no_accept_during_resp_a: assert property (no_accept_during_resp_p) else begin
		assert_errors++;
		$error("request ready was high while a response was pending");
	end

	reset_quiet_a: assert property (reset_quiet_p) else begin
		assert_errors++;
		$error("valid or ready signal active right after reset");
	end

endmodule

bind l2_cache_top l2_cache_assertions u_assertions (
	.clk           (clk),
	.reset         (reset),
	.proc_req_rdy  (proc_req_rdy),
	.proc_resp     (proc_resp),
	.proc_resp_val (proc_resp_val),
	.proc_resp_rdy (proc_resp_rdy),
	.mem_req       (mem_req),
	.mem_req_val   (mem_req_val),
	.mem_req_rdy   (mem_req_rdy),
	.mem_resp_rdy  (mem_resp_rdy)
);

// ==== tb/tb_l2_cache.sv ====
// Testbench with clock, reset, line memory model, data file stimulus and result checks
module tb_l2_cache
	import cache_cfg_pkg::*;
	import mem_msg_pkg::*;
();

	localparam int          TIMEOUT = 200;
	localparam int unsigned SEED    = 32'hca02790d;

	logic       clk;
	logic       reset;
	word_req_t  proc_req;
	logic       proc_req_domain;
	logic       proc_req_val;
	logic       proc_req_rdy;
	word_resp_t proc_resp;
	logic       proc_resp_val;
	logic       proc_resp_rdy;
	line_req_t  mem_req;
	logic       mem_req_val;
	logic       mem_req_rdy;
	line_resp_t mem_resp;
	logic       mem_resp_val;
	logic       mem_resp_rdy;

	// Main memory lines that have been written
	logic [LINE_W-1:0] mem_lines [logic [LINE_ADDR_W-1:0]];
	// Memory requests seen in the current transaction
	int mem_reqs;

	int resp_errors    = 0;
	int count_errors   = 0;
	int latency_errors = 0;
	int other_errors   = 0;
	int timeout_errors = 0;

	l2_cache_top #(
		.BOUNDARY_RESET (32'hc000),
		.NUM_LINES      (16)
	) DUT (
		.clk            (clk),
		.reset          (reset),
		.proc_req       (proc_req),
		.proc_req_domain(proc_req_domain),
		.proc_req_val   (proc_req_val),
		.proc_req_rdy   (proc_req_rdy),
		.proc_resp      (proc_resp),
		.proc_resp_val  (proc_resp_val),
		.proc_resp_rdy  (proc_resp_rdy),
		.mem_req        (mem_req),
		.mem_req_val    (mem_req_val),
		.mem_req_rdy    (mem_req_rdy),
		.mem_resp       (mem_resp),
		.mem_resp_val   (mem_resp_val),
		.mem_resp_rdy   (mem_resp_rdy)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ------------------------------------------------------------
	// Compare tasks and run control
	// ------------------------------------------------------------

	task automatic check_resp(input word_resp_t exp, input word_resp_t got, input string what);
		if (got !== exp) begin
			resp_errors++;
			$display("FAIL %0t: %s expected op %0d data %h, got op %0d data %h",
				$time, what, exp.op, exp.data, got.op, got.data);
		end
	endtask

	task automatic check_mem_count(input int exp, input int got);
		if (got != exp) begin
			count_errors++;
			$display("FAIL %0t: expected %0d memory requests, saw %0d", $time, exp, got);
		end
	endtask

	task automatic check_latency(input int exp, input int got);
		if (got != exp) begin
			latency_errors++;
			$display("FAIL %0t: expected response after %0d cycles, took %0d", $time, exp, got);
		end
	endtask

	task automatic finish_run();
		int total;
		total = resp_errors + count_errors + latency_errors + other_errors + timeout_errors
			+ DUT.u_assertions.assert_errors;
		$display("Errors: resp %0d, count %0d, latency %0d, other %0d, timeout %0d, assert %0d",
			resp_errors, count_errors, latency_errors, other_errors, timeout_errors,
			DUT.u_assertions.assert_errors);
		if (total == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	endtask

	task automatic abort_on_timeout(input string what);
		timeout_errors++;
		$display("Timed out at time %0t: %s", $time, what);
		finish_run();
	endtask

	// ------------------------------------------------------------
	// Memory model
	// ------------------------------------------------------------

	// Unwritten lines hold each word's own byte address
	function automatic logic [LINE_W-1:0] line_at(input logic [LINE_ADDR_W-1:0] laddr);
		logic [LINE_W-1:0] l;
		if (mem_lines.exists(laddr)) begin
			return mem_lines[laddr];
		end
		for (int i = 0; i < WORDS_PER_LINE; i++) begin
			l[i*WORD_W +: WORD_W] = {laddr, 4'h0} + 32'(i * 4);
		end
		return l;
	endfunction

	initial begin : mem_model
		line_req_t         req;
		logic [LINE_W-1:0] line;
		int unsigned       delay;
		int                waited;
		mem_req_rdy  = 1'b0;
		mem_resp_val = 1'b0;
		mem_resp     = '0;
		void'($urandom(SEED));
		forever begin
			@(posedge clk);
			#1;
			// Ready drops on about one cycle in four
			mem_req_rdy = !reset && ($urandom_range(3, 0) != 0);
			if (mem_req_val && mem_req_rdy) begin
				req = mem_req;
				@(posedge clk);
				#1;
				mem_req_rdy = 1'b0;
				mem_reqs++;
				line = line_at(req.addr);
				if (req.op == MEM_WRITE) begin
					for (int i = 0; i < WORDS_PER_LINE; i++) begin
						if (req.mask[i]) begin
							line[i*WORD_W +: WORD_W] = req.data[i*WORD_W +: WORD_W];
						end
					end
					mem_lines[req.addr] = line;
				end
				delay = $urandom_range(4, 1);
				repeat (delay) begin
					@(posedge clk);
					#1;
				end
				mem_resp_val  = 1'b1;
				mem_resp.op   = req.op;
				mem_resp.data = line;
				waited = 0;
				while (!mem_resp_rdy) begin
					if (waited == TIMEOUT) begin
						abort_on_timeout("memory response was never accepted");
					end
					@(posedge clk);
					#1;
					waited++;
				end
				@(posedge clk);
				#1;
				mem_resp_val = 1'b0;
			end
		end
	end

	// ------------------------------------------------------------
	// Transactions
	// ------------------------------------------------------------

	task automatic run_transaction(input mem_op_t op, input logic domain,
		input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data,
		input logic [WORD_W-1:0] exp_data, input int exp_count, input int hold);
		word_resp_t exp_resp;
		int         cycles;
		int         latency;
		exp_resp.op   = op;
		exp_resp.data = exp_data;
		mem_reqs        = 0;
		proc_req.op     = op;
		proc_req.addr   = addr;
		proc_req.data   = data;
		proc_req_domain = domain;
		proc_req_val    = 1'b1;
		cycles = 0;
		while (!proc_req_rdy) begin
			if (cycles == TIMEOUT) begin
				abort_on_timeout("processor request was never accepted");
			end
			@(posedge clk);
			#1;
			cycles++;
		end
		@(posedge clk);
		#1;
		proc_req_val = 1'b0;
		latency = 0;
		while (!proc_resp_val) begin
			if (latency == TIMEOUT) begin
				abort_on_timeout("no processor response");
			end
			@(posedge clk);
			#1;
			latency++;
		end
		check_resp(exp_resp, proc_resp, "response");
		// Local answers take 2 cycles and read hits 3
		if (exp_count == 0) begin
			if (addr == CTRL_REG_ADDR) begin
				check_latency(2, latency);
			end else if (op == MEM_READ) begin
				check_latency(3, latency);
			end
		end
		for (int i = 0; i < hold; i++) begin
			@(posedge clk);
			#1;
			check_resp(exp_resp, proc_resp, "held response");
			if (!proc_resp_val || proc_req_rdy) begin
				other_errors++;
				$display("FAIL %0t: handshake broken while the response was held", $time);
			end
		end
		proc_resp_rdy = 1'b1;
		@(posedge clk);
		#1;
		proc_resp_rdy = 1'b0;
		check_mem_count(exp_count, mem_reqs);
	endtask

	initial begin : stimulus
		int          fd;
		int          n;
		int          txn_count;
		string       text;
		logic [31:0] op_v;
		logic [31:0] domain_v;
		logic [31:0] addr_v;
		logic [31:0] data_v;
		logic [31:0] exp_v;
		int          count_v;
		reset           = 1'b1;
		proc_req        = '0;
		proc_req_domain = 1'b0;
		proc_req_val    = 1'b0;
		proc_resp_rdy   = 1'b0;
		txn_count       = 0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		fd = $fopen("tb/l2_cache_testdata.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("Could not open the test data file");
		end else begin
			while ($fgets(text, fd) != 0) begin
				if (text.len() > 0 && text[0] != "#") begin
					n = $sscanf(text, "%h %h %h %h %h %d",
						op_v, domain_v, addr_v, data_v, exp_v, count_v);
					if (n == 6) begin
						// Back-pressure of 0, 2, 4 or 6 cycles in turn
						run_transaction(mem_op_t'(op_v[0]), domain_v[0], addr_v, data_v,
							exp_v, count_v, (txn_count % 4) * 2);
						txn_count++;
					end else if (n > 0) begin
						other_errors++;
						$display("Malformed test data line: %s", text);
					end
				end
			end
			$fclose(fd);
			if (txn_count == 0) begin
				other_errors++;
				$display("The test data file held no transactions");
			end
		end
		finish_run();
	end

endmodule

// ==== tb/l2_cache_testdata.txt ====
# op domain addr data exp_data exp_mem_reqs
# op 0 read 1 write, hex fields except the last, which is a decimal request count
0 0 00000100 00000000 00000100 1
0 0 00000100 00000000 00000100 0
0 0 00000108 00000000 00000108 0
1 0 00000104 deadbeef 00000000 1
0 0 00000104 00000000 deadbeef 0
1 0 00000200 12345678 00000000 1
0 0 00000200 00000000 12345678 1
0 0 00000204 00000000 00000204 0
0 0 00000100 00000000 00000100 1
0 0 00000104 00000000 deadbeef 0
0 0 0000c000 00000000 0000c000 1
0 0 0000c000 00000000 0000c000 1
1 0 0000d004 a5a5a5a5 00000000 1
0 0 0000d004 00000000 a5a5a5a5 1
0 0 00000000 00000000 00000000 1
1 0 00000000 11112222 00000000 1
0 0 00000000 00000000 11112222 1
1 0 00000004 00010000 00000000 0
0 0 0000c010 00000000 0000c010 1
0 0 0000c010 00000000 0000c010 1
0 1 00000004 00000000 00000000 0
1 1 00000004 00010000 00000000 0
0 0 0000c010 00000000 0000c010 1
0 0 0000c010 00000000 0000c010 0
0 0 0000d004 00000000 a5a5a5a5 1
0 0 0000d004 00000000 a5a5a5a5 0
0 0 00000000 00000000 11112222 1

// ==== project.f ====
verilog/cache_cfg_pkg.sv
verilog/mem_msg_pkg.sv
verilog/request_router.sv
verilog/line_cache.sv
verilog/mem_port_arbiter.sv
verilog/l2_cache_top.sv
tb/l2_cache_assertions.sv
tb/tb_l2_cache.sv
